//--- all.f
+incdir+include
design/isaPkg.sv
design/corePkg.sv
design/controller.sv
design/alu.sv
design/regFile.sv
design/dataMem.sv
design/pcUnit.sv
design/mipsCore.sv
bench/retireChecker.sv
bench/tbMipsCore.sv

//--- bench/retireChecker.sv
`include "mips_defines.svh"

module retireChecker (
    input  logic               clk,
    input  logic               arstN,
    input  logic [`DATA_W-1:0] pc,
    input  logic               retireValid,
    input  corePkg::retireT    retire,
    input  logic               expPush,
    input  corePkg::retireT    expRetire,
    input  logic [`DATA_W-1:0] expNextPc,
    input  logic               expCheckData,
    output int                 valueErrors,
    output int                 unexpectedBeats,
    output int                 pending
);
    timeunit 1ns;
    timeprecision 100ps;

    corePkg::retireT    expQ [$];
    logic [`DATA_W-1:0] nextPcQ [$];
    logic               checkDataQ [$];
    logic [`DATA_W-1:0] lastPc;

    task automatic flagValue(input string what, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] want);
        valueErrors++;
        $display("Error %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic compareBeat(input corePkg::retireT want,
                               input logic [`DATA_W-1:0] wantNextPc,
                               input logic checkData);
        if (retire.pc !== want.pc) begin
            flagValue("retire pc", retire.pc, want.pc);
        end
        if (retire.regWrite !== want.regWrite) begin
            flagValue("retire regWrite", 32'(retire.regWrite), 32'(want.regWrite));
        end
        if (want.regWrite && (retire.regAddr !== want.regAddr)) begin
            flagValue("destination register", 32'(retire.regAddr), 32'(want.regAddr));
        end
        if (checkData && (retire.data !== want.data)) begin
            flagValue("retire data", retire.data, want.data);
        end
        if (pc !== wantNextPc) begin
            flagValue("next pc", pc, wantNextPc);
        end
    endtask

    // sampled half a cycle after the rising edge
    initial begin
        valueErrors     = 0;
        unexpectedBeats = 0;
        pending         = 0;
        lastPc          = `RESET_PC;
        forever begin
            @(negedge clk);
            if (!arstN) begin
                lastPc = `RESET_PC;
            end else begin
                if (retireValid) begin
                    if (expQ.size() == 0) begin
                        unexpectedBeats++;
                        $display("A retire beat for pc %h came with no instruction outstanding",
                                 retire.pc);
                    end else begin
                        compareBeat(expQ.pop_front(), nextPcQ.pop_front(),
                                    checkDataQ.pop_front());
                    end
                end else if (pc !== lastPc) begin
                    flagValue("pc in an idle cycle", pc, lastPc);   // also covers reset pc
                end
                lastPc = pc;
                if (expPush) begin
                    expQ.push_back(expRetire);
                    nextPcQ.push_back(expNextPc);
                    checkDataQ.push_back(expCheckData);
                end
                pending = expQ.size();
            end
        end
    end

endmodule

//--- bench/tbMipsCore.sv
`include "mips_defines.svh"

module tbMipsCore;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0]        instrBits;
        logic               regWrite;
        logic [4:0]         dest;
        logic [`DATA_W-1:0] data;
        logic               checkData;   // data compared on writes and stores
        logic [`DATA_W-1:0] nextPc;
    } stepT;

    logic               clk;
    logic               arstN;
    isaPkg::instrT      instr;
    logic               instrValid;
    logic [`DATA_W-1:0] pc;
    logic               retireValid;
    corePkg::retireT    retire;
    logic               expPush;
    corePkg::retireT    expRetire;
    logic [`DATA_W-1:0] expNextPc;
    logic               expCheckData;
    int                 valueErrors;
    int                 unexpectedBeats;
    int                 pending;
    int                 timeouts;
    int                 seed;
    stepT               steps [$];

    mipsCore u_mipsCore (
        .clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
        .pc(pc), .retireValid(retireValid), .retire(retire)
    );

    retireChecker u_retireChecker (
        .clk(clk), .arstN(arstN), .pc(pc), .retireValid(retireValid), .retire(retire),
        .expPush(expPush), .expRetire(expRetire), .expNextPc(expNextPc),
        .expCheckData(expCheckData), .valueErrors(valueErrors),
        .unexpectedBeats(unexpectedBeats), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // instruction encoding
    function automatic logic [31:0] rType(input isaPkg::functT fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        return {isaPkg::opRtype, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(input isaPkg::opcodeT op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input isaPkg::opcodeT op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic expectWrite(input logic [31:0] bits, input logic [4:0] dest,
                               input logic [31:0] data, input logic [31:0] nextPc);
        steps.push_back('{bits, 1'b1, dest, data, 1'b1, nextPc});
    endtask

    task automatic expectStore(input logic [31:0] bits, input logic [31:0] addr,
                               input logic [31:0] nextPc);
        steps.push_back('{bits, 1'b0, 5'd0, addr, 1'b1, nextPc});
    endtask

    task automatic expectFlow(input logic [31:0] bits, input logic [31:0] nextPc);
        steps.push_back('{bits, 1'b0, 5'd0, 32'd0, 1'b0, nextPc});
    endtask

    ////////////////////////////////////////
    // program, one line per instruction
    task automatic buildProgram();
        expectWrite(iType(isaPkg::opAddi, 0, 1, 16'hFFFB), 1, 32'hFFFF_FFFB, 32'h04);
        expectWrite(iType(isaPkg::opOri, 0, 2, 16'h8001), 2, 32'h0000_8001, 32'h08);
        expectWrite(iType(isaPkg::opAndi, 1, 3, 16'hFF0F), 3, 32'h0000_FF0B, 32'h0C);
        expectWrite(iType(isaPkg::opAddi, 0, 4, 16'h0007), 4, 32'h7, 32'h10);
        expectWrite(rType(isaPkg::fnAdd, 1, 4, 5, 0), 5, 32'h2, 32'h14);
        expectWrite(rType(isaPkg::fnSub, 1, 4, 6, 0), 6, 32'hFFFF_FFF4, 32'h18);
        expectWrite({isaPkg::opMul, 5'd1, 5'd4, 5'd7, 5'd0, 6'h02}, 7, 32'hFFFF_FFDD, 32'h1C);
        expectWrite(rType(isaPkg::fnAnd, 2, 3, 8, 0), 8, 32'h8001, 32'h20);
        expectWrite(rType(isaPkg::fnOr, 2, 4, 9, 0), 9, 32'h8007, 32'h24);
        expectWrite(rType(isaPkg::fnXor, 3, 4, 10, 0), 10, 32'hFF0C, 32'h28);
        expectWrite(rType(isaPkg::fnNor, 0, 4, 11, 0), 11, 32'hFFFF_FFF8, 32'h2C);
        expectWrite(rType(isaPkg::fnSlt, 1, 4, 12, 0), 12, 32'h1, 32'h30);   // -5 < 7
        expectWrite(rType(isaPkg::fnSlt, 4, 1, 13, 0), 13, 32'h0, 32'h34);
        expectWrite(iType(isaPkg::opSlti, 6, 14, 16'hFFFC), 14, 32'h1, 32'h38);
        expectWrite(rType(isaPkg::fnSll, 0, 4, 15, 4), 15, 32'h70, 32'h3C);
        expectWrite(rType(isaPkg::fnSrl, 0, 1, 16, 28), 16, 32'hF, 32'h40);
        expectWrite(iType(isaPkg::opAddi, 0, 17, 16'h0040), 17, 32'h40, 32'h44);
        expectStore(iType(isaPkg::opSw, 17, 6, 16'h0), 32'h40, 32'h48);
        expectStore(iType(isaPkg::opSh, 17, 2, 16'h4), 32'h44, 32'h4C);
        expectStore(iType(isaPkg::opSb, 17, 1, 16'h6), 32'h46, 32'h50);
        expectWrite(iType(isaPkg::opLw, 17, 18, 16'h0), 18, 32'hFFFF_FFF4, 32'h54);
        expectWrite(iType(isaPkg::opLh, 17, 19, 16'h4), 19, 32'hFFFF_8001, 32'h58);
        expectWrite(iType(isaPkg::opLb, 17, 20, 16'h6), 20, 32'hFFFF_FFFB, 32'h5C);
        expectWrite(iType(isaPkg::opLw, 17, 21, 16'h4), 21, 32'h00FB_8001, 32'h60);
        expectFlow(iType(isaPkg::opBeq, 4, 4, 16'h2), 32'h6C);
        expectFlow(iType(isaPkg::opBeq, 4, 1, 16'h5), 32'h70);
        expectFlow(iType(isaPkg::opBne, 4, 1, 16'h1), 32'h78);
        expectFlow(iType(isaPkg::opBne, 5, 5, 16'h7), 32'h7C);
        expectFlow(iType(isaPkg::opRegimm, 5, 1, 16'h1), 32'h84);   // bgez
        expectFlow(iType(isaPkg::opRegimm, 1, 1, 16'h3), 32'h88);
        expectFlow(iType(isaPkg::opRegimm, 1, 0, 16'h2), 32'h94);   // bltz
        expectFlow(iType(isaPkg::opRegimm, 0, 0, 16'h2), 32'h98);
        expectFlow(iType(isaPkg::opBgtz, 4, 0, 16'h1), 32'hA0);
        expectFlow(iType(isaPkg::opBgtz, 0, 0, 16'h1), 32'hA4);
        expectFlow(iType(isaPkg::opBlez, 0, 0, 16'h2), 32'hB0);
        expectFlow(iType(isaPkg::opBlez, 4, 0, 16'h2), 32'hB4);
        expectFlow(iType(isaPkg::opBlez, 1, 0, 16'hFFFC), 32'hA8);  // backward
        expectFlow(jType(isaPkg::opJ, 26'h100), 32'h400);
        expectWrite(jType(isaPkg::opJal, 26'h200), 31, 32'h404, 32'h800);
        expectFlow(rType(isaPkg::fnJr, 31, 0, 0, 0), 32'h404);
        expectWrite(iType(isaPkg::opAddi, 4, 0, 16'h5), 0, 32'hC, 32'h408);
        expectWrite(rType(isaPkg::fnOr, 0, 31, 22, 0), 22, 32'h404, 32'h40C);  // r0 reads zero
        expectWrite(rType(isaPkg::fnAdd, 15, 16, 23, 0), 23, 32'h7F, 32'h410);
    endtask

    initial begin
        int                 gap;
        int                 drainCycles;
        logic [`DATA_W-1:0] curPc;
        seed         = 32'h5fc7_99f1;
        arstN        = 1'b0;
        instr        = '0;
        instrValid   = 1'b0;
        expPush      = 1'b0;
        expRetire    = '0;
        expNextPc    = '0;
        expCheckData = 1'b0;
        timeouts     = 0;
        curPc        = `RESET_PC;
        buildProgram();

        repeat (5) @(posedge clk);
        #1 arstN = 1'b1;
        repeat (4) @(posedge clk);   // idle, nothing may retire
        #1;

        foreach (steps[i]) begin
            instr        = isaPkg::instrT'(steps[i].instrBits);
            instrValid   = 1'b1;
            expRetire    = '{curPc, steps[i].regWrite, steps[i].dest, steps[i].data};
            expNextPc    = steps[i].nextPc;
            expCheckData = steps[i].checkData;
            expPush      = 1'b1;
            curPc        = steps[i].nextPc;
            @(posedge clk);
            #1;
            instrValid = 1'b0;
            expPush    = 1'b0;
            gap        = $unsigned($random(seed)) % 3;   // bubbles
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end

        drainCycles = 0;
        while ((pending != 0) && (drainCycles < 50)) begin
            @(posedge clk);
            drainCycles++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("Timed out waiting for %0d outstanding retire beats", pending);
        end
        repeat (3) @(posedge clk);

        $display("value errors %0d, unexpected retire beats %0d, timeouts %0d",
                 valueErrors, unexpectedBeats, timeouts);
        if ((valueErrors == 0) && (unexpectedBeats == 0) && (timeouts == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- design/alu.sv
`include "mips_defines.svh"

module alu (
    input  corePkg::aluOpT     op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] result,
    output logic               gt,
    output logic               lt,
    output logic               eq
);

    localparam int ShW = $clog2(`DATA_W);

    // signed compare of a against b, used by slt and branches
    assign gt = $signed(a) > $signed(b);
    assign lt = $signed(a) < $signed(b);
    assign eq = (a == b);

    always_comb begin
        case (op)
            corePkg::aluAdd: result = a + b;
            corePkg::aluSub: result = a - b;
            corePkg::aluMul: result = a * b;              // low half only
            corePkg::aluSll: result = a << b[ShW-1:0];
            corePkg::aluSrl: result = a >> b[ShW-1:0];
            corePkg::aluAnd: result = a & b;
            corePkg::aluOr:  result = a | b;
            corePkg::aluXor: result = a ^ b;
            corePkg::aluNor: result = ~(a | b);
            corePkg::aluSlt: result = {{(`DATA_W-1){1'b0}}, lt};
            default:         result = '0;
        endcase
    end

endmodule

//--- design/controller.sv
module controller (
    input  isaPkg::instrT instr,
    input  logic          gt,
    input  logic          lt,
    input  logic          eq,
    output corePkg::ctrlT ctrl
);

    always_comb begin
        ctrl          = '0;                 // nop unless decoded below
        ctrl.memRead  = corePkg::memNone;
        ctrl.memWrite = corePkg::memNone;
        ctrl.aluOp    = corePkg::aluNone;

        case (instr.opcode)
            ////////////////////////////////////////
            // register-register
            isaPkg::opRtype: begin
                ctrl.regDst = 1'b1;
                case (instr.funct)
                    isaPkg::fnSll: begin
                        ctrl.aluOp        = corePkg::aluSll;
                        ctrl.shiftControl = 1'b1;
                    end
                    isaPkg::fnSrl: begin
                        ctrl.aluOp        = corePkg::aluSrl;
                        ctrl.shiftControl = 1'b1;
                    end
                    isaPkg::fnJr:  ctrl.jr    = 1'b1;
                    isaPkg::fnAdd: ctrl.aluOp = corePkg::aluAdd;
                    isaPkg::fnSub: ctrl.aluOp = corePkg::aluSub;
                    isaPkg::fnAnd: ctrl.aluOp = corePkg::aluAnd;
                    isaPkg::fnOr:  ctrl.aluOp = corePkg::aluOr;
                    isaPkg::fnXor: ctrl.aluOp = corePkg::aluXor;
                    isaPkg::fnNor: ctrl.aluOp = corePkg::aluNor;
                    isaPkg::fnSlt: ctrl.aluOp = corePkg::aluSlt;
                    default:       ctrl.aluOp = corePkg::aluNone;
                endcase
                ctrl.regWrite = (ctrl.aluOp != corePkg::aluNone);   // jr, bad funct
            end
            isaPkg::opMul: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                ctrl.aluOp    = corePkg::aluMul;
            end

            ////////////////////////////////////////
            // immediates
            isaPkg::opAddi, isaPkg::opSlti, isaPkg::opAndi, isaPkg::opOri,
            isaPkg::opXori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                case (instr.opcode)
                    isaPkg::opAddi: ctrl.aluOp = corePkg::aluAdd;
                    isaPkg::opSlti: ctrl.aluOp = corePkg::aluSlt;
                    isaPkg::opAndi: ctrl.aluOp = corePkg::aluAnd;
                    isaPkg::opOri:  ctrl.aluOp = corePkg::aluOr;
                    default:        ctrl.aluOp = corePkg::aluXor;
                endcase
                ctrl.immZeroExt = (ctrl.aluOp == corePkg::aluAnd) ||
                                  (ctrl.aluOp == corePkg::aluOr) ||
                                  (ctrl.aluOp == corePkg::aluXor);
            end

            ////////////////////////////////////////
            // loads and stores, address = rs + imm
            isaPkg::opLw, isaPkg::opLh, isaPkg::opLb: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluOp    = corePkg::aluAdd;
                ctrl.memRead  = (instr.opcode == isaPkg::opLw) ? corePkg::memWord :
                                (instr.opcode == isaPkg::opLh) ? corePkg::memHalf :
                                                                 corePkg::memByte;
            end
            isaPkg::opSw, isaPkg::opSh, isaPkg::opSb: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = corePkg::aluAdd;
                ctrl.memWrite = (instr.opcode == isaPkg::opSw) ? corePkg::memWord :
                                (instr.opcode == isaPkg::opSh) ? corePkg::memHalf :
                                                                 corePkg::memByte;
            end

            ////////////////////////////////////////
            // branches and jumps
            isaPkg::opBeq: ctrl.pcSrc = eq;
            isaPkg::opBne: ctrl.pcSrc = !eq;
            isaPkg::opRegimm: begin
                ctrl.cmpZero = 1'b1;
                case (instr.rt)
                    5'b00001: ctrl.pcSrc = gt || eq;    // bgez
                    5'b00000: ctrl.pcSrc = lt;          // bltz
                    default:  ctrl.pcSrc = 1'b0;
                endcase
            end
            isaPkg::opBgtz: begin
                ctrl.cmpZero = 1'b1;
                ctrl.pcSrc   = gt;
            end
            isaPkg::opBlez: begin
                ctrl.cmpZero = 1'b1;
                ctrl.pcSrc   = lt || eq;
            end
            isaPkg::opJ: ctrl.jump = 1'b1;
            isaPkg::opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.jal      = 1'b1;
            end
            default: ctrl.pcSrc = 1'b0;
        endcase
    end

endmodule

//--- design/corePkg.sv
`include "mips_defines.svh"

package corePkg;

    typedef enum logic [4:0] {
        aluAdd  = 5'b00001,
        aluSub  = 5'b00010,
        aluMul  = 5'b00011,
        aluSll  = 5'b00100,
        aluSrl  = 5'b00101,
        aluAnd  = 5'b00110,
        aluOr   = 5'b00111,
        aluXor  = 5'b01000,
        aluNor  = 5'b01101,
        aluSlt  = 5'b01110,
        aluNone = 5'b11111    // result zero, flags still valid
    } aluOpT;

    typedef enum logic [1:0] {
        memNone = 2'b00,
        memWord = 2'b01,
        memHalf = 2'b10,
        memByte = 2'b11
    } memSizeT;

    typedef struct packed {
        logic    regWrite;
        logic    aluSrc;        // immediate as operand b
        logic    regDst;        // rd, else rt
        logic    immZeroExt;
        logic    cmpZero;       // operand b forced to zero
        memSizeT memRead;
        memSizeT memWrite;
        logic    memToReg;      // write back load data
        logic    jump;
        logic    jr;
        logic    jal;
        aluOpT   aluOp;
        logic    shiftControl;  // a = rt, b = shamt
        logic    pcSrc;         // branch taken
    } ctrlT;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic               regWrite;
        logic [4:0]         regAddr;     // destination register
        logic [`DATA_W-1:0] data;
    } retireT;

endpackage

//--- design/dataMem.sv
`include "mips_defines.svh"

module dataMem #(
    parameter int Bytes = `DMEM_BYTES
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic [`DATA_W-1:0] addr,
    input  corePkg::memSizeT   wSize,
    input  logic [`DATA_W-1:0] wData,
    input  corePkg::memSizeT   rSize,
    output logic [`DATA_W-1:0] rData
);

    localparam int AddrW = $clog2(Bytes);

    logic [7:0]       mem [Bytes];
    logic [AddrW-1:0] a0;
    logic [AddrW-1:0] a1;
    logic [AddrW-1:0] a2;
    logic [AddrW-1:0] a3;

    assign a0 = addr[AddrW-1:0];    // wraps at Bytes
    assign a1 = a0 + AddrW'(1);
    assign a2 = a0 + AddrW'(2);
    assign a3 = a0 + AddrW'(3);

    // little endian, lowest byte at addr
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Bytes; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wSize != corePkg::memNone) mem[a0] <= wData[7:0];
            if (wSize == corePkg::memWord || wSize == corePkg::memHalf) mem[a1] <= wData[15:8];
            if (wSize == corePkg::memWord) begin
                mem[a2] <= wData[23:16];
                mem[a3] <= wData[31:24];
            end
        end
    end

    always_comb begin
        case (rSize)
            corePkg::memWord: rData = {mem[a3], mem[a2], mem[a1], mem[a0]};
            corePkg::memHalf: rData = {{(`DATA_W-16){mem[a1][7]}}, mem[a1], mem[a0]};
            corePkg::memByte: rData = {{(`DATA_W-8){mem[a0][7]}}, mem[a0]};
            default:          rData = '0;
        endcase
    end

endmodule

//--- design/isaPkg.sv
package isaPkg;

    typedef enum logic [5:0] {
        opRtype  = 6'b000000,
        opRegimm = 6'b000001,   // bgez / bltz, picked by rt
        opJ      = 6'b000010,
        opJal    = 6'b000011,
        opBeq    = 6'b000100,
        opBne    = 6'b000101,
        opBlez   = 6'b000110,
        opBgtz   = 6'b000111,
        opAddi   = 6'b001000,
        opSlti   = 6'b001010,
        opAndi   = 6'b001100,
        opOri    = 6'b001101,
        opXori   = 6'b001110,
        opMul    = 6'b011100,
        opLb     = 6'b100000,
        opLh     = 6'b100001,
        opLw     = 6'b100011,
        opSb     = 6'b101000,
        opSh     = 6'b101001,
        opSw     = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll = 6'b000000,
        fnSrl = 6'b000010,
        fnJr  = 6'b001000,
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnXor = 6'b100110,
        fnNor = 6'b100111,
        fnSlt = 6'b101010
    } functT;

    // imm16 and the jump index overlay the low fields
    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } instrT;

endpackage

//--- design/mipsCore.sv
`include "mips_defines.svh"

module mipsCore (
    input  logic               clk,
    input  logic               arstN,
    input  isaPkg::instrT      instr,
    input  logic               instrValid,
    output logic [`DATA_W-1:0] pc,
    output logic               retireValid,
    output corePkg::retireT    retire
);

    corePkg::ctrlT      ctrl;
    corePkg::memSizeT   memWriteSize;
    logic [31:0]        instrBits;
    logic [15:0]        imm;
    logic [25:0]        jumpIndex;
    logic [`DATA_W-1:0] rsValue;
    logic [`DATA_W-1:0] rtValue;
    logic [`DATA_W-1:0] immExt;
    logic [`DATA_W-1:0] opA;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] aluResult;
    logic [`DATA_W-1:0] loadData;
    logic [`DATA_W-1:0] wbData;
    logic [`DATA_W-1:0] pcPlus4;
    logic [4:0]         destReg;
    logic               gt;
    logic               lt;
    logic               eq;

    assign instrBits = instr;
    assign imm       = instrBits[15:0];
    assign jumpIndex = instrBits[25:0];

    controller u_controller (.instr(instr), .gt(gt), .lt(lt), .eq(eq), .ctrl(ctrl));

    regFile u_regFile (
        .clk(clk), .arstN(arstN),
        .rAddrA(instr.rs), .rAddrB(instr.rt),
        .wEn(instrValid && ctrl.regWrite), .wAddr(destReg), .wData(wbData),
        .rDataA(rsValue), .rDataB(rtValue)
    );

    ////////////////////////////////////////
    // operands
    assign immExt = ctrl.immZeroExt ? {{(`DATA_W-16){1'b0}}, imm}
                                    : {{(`DATA_W-16){imm[15]}}, imm};
    assign opA = ctrl.shiftControl ? rtValue : rsValue;
    assign opB = ctrl.shiftControl ? {{(`DATA_W-5){1'b0}}, instr.shamt} :
                 ctrl.cmpZero      ? '0 :
                 ctrl.aluSrc       ? immExt : rtValue;

    alu u_alu (.op(ctrl.aluOp), .a(opA), .b(opB), .result(aluResult), .gt(gt), .lt(lt), .eq(eq));

    assign memWriteSize = instrValid ? ctrl.memWrite : corePkg::memNone;

    dataMem #(.Bytes(`DMEM_BYTES)) u_dataMem (
        .clk(clk), .arstN(arstN), .addr(aluResult),
        .wSize(memWriteSize), .wData(rtValue), .rSize(ctrl.memRead), .rData(loadData)
    );

    pcUnit u_pcUnit (
        .clk(clk), .arstN(arstN), .advance(instrValid), .ctrl(ctrl), .imm(imm),
        .jumpIndex(jumpIndex), .rsValue(rsValue), .pc(pc), .pcPlus4(pcPlus4)
    );

    ////////////////////////////////////////
    // write back and retire
    assign wbData  = ctrl.jal      ? pcPlus4 :
                     ctrl.memToReg ? loadData : aluResult;   // stores land on the address
    assign destReg = ctrl.jal ? 5'd31 : (ctrl.regDst ? instr.rd : instr.rt);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) retireValid <= 1'b0;
        else retireValid <= instrValid;
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            retire.pc       <= pc;
            retire.regWrite <= ctrl.regWrite;
            retire.regAddr  <= destReg;
            retire.data     <= wbData;
        end
    end

endmodule

//--- design/pcUnit.sv
`include "mips_defines.svh"

module pcUnit (
    input  logic               clk,
    input  logic               arstN,
    input  logic               advance,
    input  corePkg::ctrlT      ctrl,
    input  logic [15:0]        imm,
    input  logic [25:0]        jumpIndex,
    input  logic [`DATA_W-1:0] rsValue,
    output logic [`DATA_W-1:0] pc,
    output logic [`DATA_W-1:0] pcPlus4
);

    logic [`DATA_W-1:0] branchOffset;
    logic [`DATA_W-1:0] nextPc;

    assign pcPlus4      = pc + `DATA_W'(4);
    assign branchOffset = {{(`DATA_W-18){imm[15]}}, imm, 2'b00};

    // jr over jump over taken branch
    always_comb begin
        if (ctrl.jr) begin
            nextPc = rsValue;
        end else if (ctrl.jump) begin
            nextPc = {pcPlus4[`DATA_W-1 -: 4], jumpIndex, 2'b00};  // region of pc+4
        end else if (ctrl.pcSrc) begin
            nextPc = pcPlus4 + branchOffset;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) pc <= `RESET_PC;
        else if (advance) pc <= nextPc;
    end

endmodule

//--- design/regFile.sv
`include "mips_defines.svh"

module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [$clog2(`REG_CNT)-1:0]  rAddrA,
    input  logic [$clog2(`REG_CNT)-1:0]  rAddrB,
    input  logic                         wEn,
    input  logic [$clog2(`REG_CNT)-1:0]  wAddr,
    input  logic [`DATA_W-1:0]           wData,
    output logic [`DATA_W-1:0]           rDataA,
    output logic [`DATA_W-1:0]           rDataB
);

    logic [`DATA_W-1:0] regs [`REG_CNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && (wAddr != '0)) begin   // r0 stays zero
            regs[wAddr] <= wData;
        end
    end

    assign rDataA = regs[rAddrA];
    assign rDataB = regs[rAddrB];

endmodule

//--- include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath
`define DATA_W      32

// architectural registers, r0 reads zero
`define REG_CNT     32

// data memory size, power of two
`define DMEM_BYTES  256

// first pc after reset
`define RESET_PC    32'h0000_0000

`endif

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tbMipsCore \
    -o simMipsCore > build.log 2>&1 &&
    ./obj_dir/simMipsCore > sim.log 2>&1 &&
    grep -qx "Everything OK" sim.log &&
    { echo "simulation passed"; exit 0; } ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }
